/* hw/soc_map_pkg.sv */
`default_nettype none

package soc_map_pkg;

    // ------------------------------------------------------------------
    // APB widths
    // ------------------------------------------------------------------
    localparam int unsigned PaddrWidth = 16;
    localparam int unsigned PdataWidth = 32;

    typedef logic [PaddrWidth-1:0] paddr_t;
    typedef logic [PdataWidth-1:0] pdata_t;

    // ------------------------------------------------------------------
    // Address map, two 4 KiB regions, everything above is unmapped
    // ------------------------------------------------------------------
    localparam paddr_t      RegionSize  = 16'h1000;
    localparam paddr_t      RegionMask  = RegionSize - paddr_t'(1);
    localparam int unsigned OffsetWidth = $clog2(RegionSize);
    localparam paddr_t      ClintBase   = 16'h0000;
    localparam paddr_t      PlicBase    = 16'h1000;

    typedef logic [OffsetWidth-1:0] reg_off_t;

    // CLINT registers
    localparam reg_off_t MsipOff       = 12'h000;
    localparam reg_off_t MtimecmpLoOff = 12'h008;
    localparam reg_off_t MtimecmpHiOff = 12'h00C;
    localparam reg_off_t MtimeLoOff    = 12'h010;
    localparam reg_off_t MtimeHiOff    = 12'h014;

    // PLIC registers, source n priority at PrioOff + 4*n
    localparam reg_off_t PrioOff      = 12'h000;
    localparam reg_off_t PendingOff   = 12'h080;
    localparam reg_off_t EnableOff    = 12'h100;
    localparam reg_off_t ThresholdOff = 12'h200;
    localparam reg_off_t ClaimOff     = 12'h204;

endpackage

`default_nettype wire

/* hw/irq_pkg.sv */
`default_nettype none

package irq_pkg;

    localparam int unsigned NumSources  = 8;
    localparam int unsigned MaxPriority = 7;
    localparam int unsigned MtimeWidth  = 64;

    // One bit per source
    typedef logic [NumSources-1:0] src_vec_t;

    typedef logic [$clog2(MaxPriority+1)-1:0] prio_t;

    // Identifier 0 means no interrupt
    typedef logic [$clog2(NumSources)-1:0] irq_id_t;

    typedef logic [MtimeWidth-1:0] mtime_t;

    // Source 0 is reserved and never pends
    localparam src_vec_t ValidSrcMask = ~src_vec_t'(1);

endpackage

`default_nettype wire

/* hw/apb_periph_decoder.sv */
`default_nettype none

module apb_periph_decoder (
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  soc_map_pkg::paddr_t   paddr_i,
    input  soc_map_pkg::pdata_t   clint_rdata_i,
    input  soc_map_pkg::pdata_t   plic_rdata_i,
    output logic                  clint_sel_o,
    output logic                  plic_sel_o,
    output soc_map_pkg::reg_off_t offset_o,
    output soc_map_pkg::pdata_t   prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o
);
    import soc_map_pkg::*;

    logic   clint_hit;
    logic   plic_hit;
    logic   mapped;
    logic   access;
    logic   read_access;
    paddr_t region_base;

    // ------------------------------------------------------------------
    // Region decode
    // ------------------------------------------------------------------
    assign region_base = paddr_i & ~RegionMask;
    assign clint_hit   = (region_base == ClintBase);
    assign plic_hit    = (region_base == PlicBase);
    assign mapped      = clint_hit | plic_hit;

    assign clint_sel_o = psel_i & clint_hit;
    assign plic_sel_o  = psel_i & plic_hit;
    assign offset_o    = paddr_i[OffsetWidth-1:0];

    // ------------------------------------------------------------------
    // Response
    // ------------------------------------------------------------------
    // No wait states, every access cycle completes
    assign access      = psel_i & penable_i;
    assign read_access = access & ~pwrite_i;

    assign pready_o  = access;
    assign pslverr_o = access & ~mapped;

    always_comb begin
        prdata_o = '0;
        if (read_access) begin
            if (clint_hit) begin
                prdata_o = clint_rdata_i;
            end else if (plic_hit) begin
                prdata_o = plic_rdata_i;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/clint_timer.sv */
`default_nettype none

module clint_timer (
    input  logic                  clk_i,
    input  logic                  ndmreset_n,
    input  logic                  sel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  soc_map_pkg::reg_off_t offset_i,
    input  soc_map_pkg::pdata_t   wdata_i,
    output soc_map_pkg::pdata_t   rdata_o,
    output logic                  timer_irq_o,
    output logic                  ipi_o
);
    import soc_map_pkg::*;
    import irq_pkg::*;

    logic   wr_en;
    logic   rd_en;
    logic   rtc_q;
    mtime_t mtime_q;
    mtime_t mtimecmp_q;
    logic   msip_q;
    logic   timer_irq_q;

    assign wr_en = sel_i & penable_i & pwrite_i;
    assign rd_en = sel_i & penable_i & ~pwrite_i;

    // ------------------------------------------------------------------
    // Real-time tick, half the core clock
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            rtc_q <= 1'b0;
        end else begin
            rtc_q <= ~rtc_q;
        end
    end

    // Bus write wins over the tick
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            mtime_q <= '0;
        end else if (wr_en && offset_i == MtimeLoOff) begin
            mtime_q[31:0] <= wdata_i;
        end else if (wr_en && offset_i == MtimeHiOff) begin
            mtime_q[63:32] <= wdata_i;
        end else if (rtc_q) begin
            mtime_q <= mtime_q + mtime_t'(1);
        end
    end

    // ------------------------------------------------------------------
    // Compare and software interrupt registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            mtimecmp_q <= '1;
            msip_q     <= 1'b0;
        end else if (wr_en) begin
            case (offset_i)
                MsipOff:       msip_q             <= wdata_i[0];
                MtimecmpLoOff: mtimecmp_q[31:0]   <= wdata_i;
                MtimecmpHiOff: mtimecmp_q[63:32]  <= wdata_i;
                default:       ;
            endcase
        end
    end

    // Timer interrupt lags the registers by one cycle
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            timer_irq_q <= 1'b0;
        end else begin
            timer_irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    assign timer_irq_o = timer_irq_q;
    assign ipi_o       = msip_q;

    // ------------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------------
    always_comb begin
        rdata_o = '0;
        if (rd_en) begin
            case (offset_i)
                MsipOff:       rdata_o = pdata_t'(msip_q);
                MtimecmpLoOff: rdata_o = mtimecmp_q[31:0];
                MtimecmpHiOff: rdata_o = mtimecmp_q[63:32];
                MtimeLoOff:    rdata_o = mtime_q[31:0];
                MtimeHiOff:    rdata_o = mtime_q[63:32];
                default:       rdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/plic_core.sv */
`default_nettype none

module plic_core (
    input  logic                  clk_i,
    input  logic                  ndmreset_n,
    input  logic                  sel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  soc_map_pkg::reg_off_t offset_i,
    input  soc_map_pkg::pdata_t   wdata_i,
    input  irq_pkg::src_vec_t     irq_sources_i,
    output soc_map_pkg::pdata_t   rdata_o,
    output logic                  eip_o
);
    import soc_map_pkg::*;
    import irq_pkg::*;

    logic     wr_en;
    logic     rd_en;
    logic     claim_rd;
    logic     complete_wr;
    logic     prio_hit;
    reg_off_t prio_word;
    irq_id_t  prio_idx;
    irq_id_t  claim_id;
    irq_id_t  complete_id;
    prio_t    best_prio;
    prio_t    prio_q [NumSources];
    prio_t    threshold_q;
    src_vec_t enable_q;
    src_vec_t pending_q;
    src_vec_t pending_d;
    src_vec_t in_service_q;
    src_vec_t in_service_d;

    // Clamp a written value to the priority range
    function automatic prio_t sat_prio(pdata_t value);
        prio_t result;
        if (value > pdata_t'(MaxPriority)) begin
            result = prio_t'(MaxPriority);
        end else begin
            result = prio_t'(value);
        end
        return result;
    endfunction

    assign wr_en = sel_i & penable_i & pwrite_i;
    assign rd_en = sel_i & penable_i & ~pwrite_i;

    // One priority word per source
    assign prio_word = offset_i - PrioOff;
    assign prio_hit  = prio_word < reg_off_t'(4 * NumSources);
    assign prio_idx  = prio_word[2 +: $bits(irq_id_t)];

    assign claim_rd    = rd_en && offset_i == ClaimOff;
    assign complete_wr = wr_en && offset_i == ClaimOff && wdata_i < pdata_t'(NumSources);
    assign complete_id = wdata_i[$bits(irq_id_t)-1:0];

    // ------------------------------------------------------------------
    // Target arbitration
    // ------------------------------------------------------------------
    // Strict compare, so the lowest identifier wins a tie
    always_comb begin
        claim_id  = '0;
        best_prio = threshold_q;
        for (int i = 1; i < NumSources; i++) begin
            if (pending_q[i] && enable_q[i] && prio_q[i] > best_prio) begin
                claim_id  = irq_id_t'(i);
                best_prio = prio_q[i];
            end
        end
    end

    assign eip_o = (claim_id != '0);

    // ------------------------------------------------------------------
    // Gateway, pending and in-service
    // ------------------------------------------------------------------
    always_comb begin
        pending_d    = pending_q | (irq_sources_i & ~in_service_q & ValidSrcMask);
        in_service_d = in_service_q;
        if (claim_rd && claim_id != '0) begin
            pending_d[claim_id]    = 1'b0;
            in_service_d[claim_id] = 1'b1;
        end
        if (complete_wr) begin
            in_service_d[complete_id] = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            pending_q    <= pending_d;
            in_service_q <= in_service_d;
        end
    end

    // ------------------------------------------------------------------
    // Configuration registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            for (int i = 0; i < NumSources; i++) begin
                prio_q[i] <= '0;
            end
            enable_q    <= '0;
            threshold_q <= '0;
        end else if (wr_en) begin
            // Priority of reserved source stays 0
            if (prio_hit && prio_idx != '0) begin
                prio_q[prio_idx] <= sat_prio(wdata_i);
            end
            if (offset_i == EnableOff) begin
                enable_q <= wdata_i[NumSources-1:0] & ValidSrcMask;
            end
            if (offset_i == ThresholdOff) begin
                threshold_q <= sat_prio(wdata_i);
            end
        end
    end

    // ------------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------------
    always_comb begin
        rdata_o = '0;
        if (rd_en) begin
            if (prio_hit) begin
                rdata_o = pdata_t'(prio_q[prio_idx]);
            end else begin
                case (offset_i)
                    PendingOff:   rdata_o = pdata_t'(pending_q);
                    EnableOff:    rdata_o = pdata_t'(enable_q);
                    ThresholdOff: rdata_o = pdata_t'(threshold_q);
                    ClaimOff:     rdata_o = pdata_t'(claim_id);
                    default:      rdata_o = '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hw/irq_periph_top.sv */
`default_nettype none

module irq_periph_top (
    input  logic                clk_i,
    input  logic                ndmreset_n,
    // APB completer
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  soc_map_pkg::paddr_t paddr_i,
    input  soc_map_pkg::pdata_t pwdata_i,
    output soc_map_pkg::pdata_t prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    // Interrupts
    input  irq_pkg::src_vec_t   irq_sources_i,
    output logic                timer_irq_o,
    output logic                ipi_o,
    output logic                eip_o
);

    logic                  clint_sel;
    logic                  plic_sel;
    soc_map_pkg::reg_off_t offset;
    soc_map_pkg::pdata_t   clint_rdata;
    soc_map_pkg::pdata_t   plic_rdata;

    apb_periph_decoder u_decoder (
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .clint_rdata_i (clint_rdata),
        .plic_rdata_i  (plic_rdata),
        .clint_sel_o   (clint_sel),
        .plic_sel_o    (plic_sel),
        .offset_o      (offset),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o)
    );

    clint_timer u_clint (
        .clk_i       (clk_i),
        .ndmreset_n  (ndmreset_n),
        .sel_i       (clint_sel),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .offset_i    (offset),
        .wdata_i     (pwdata_i),
        .rdata_o     (clint_rdata),
        .timer_irq_o (timer_irq_o),
        .ipi_o       (ipi_o)
    );

    plic_core u_plic (
        .clk_i         (clk_i),
        .ndmreset_n    (ndmreset_n),
        .sel_i         (plic_sel),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .offset_i      (offset),
        .wdata_i       (pwdata_i),
        .irq_sources_i (irq_sources_i),
        .rdata_o       (plic_rdata),
        .eip_o         (eip_o)
    );

endmodule

`default_nettype wire

/* sim/irq_periph_checker.sv */
`default_nettype none

module irq_periph_checker (
    input logic clk_i,
    input logic ndmreset_n,
    input logic psel_i,
    input logic penable_i,
    input logic pready_o,
    input logic pslverr_o,
    input logic timer_irq_o,
    input logic ipi_o,
    input logic eip_o
);

    logic access;

    assign access = psel_i && penable_i;

    // ------------------------------------------------------------------
    // APB response
    // ------------------------------------------------------------------
    slverr_in_access: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        pslverr_o |-> access)
        else $error("pslverr_o high outside an access cycle");

    ready_in_access: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        pready_o == access)
        else $error("pready_o does not match the access cycle");

    // First cycle out of reset
    irq_low_after_reset: assert property (@(posedge clk_i)
        $rose(ndmreset_n) |-> !timer_irq_o && !ipi_o && !eip_o)
        else $error("interrupt output high right after reset");

endmodule

bind irq_periph_top irq_periph_checker u_checker (
    .clk_i       (clk_i),
    .ndmreset_n  (ndmreset_n),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .timer_irq_o (timer_irq_o),
    .ipi_o       (ipi_o),
    .eip_o       (eip_o)
);

`default_nettype wire

/* sim/irq_periph_tb.sv */
`default_nettype none

module irq_periph_tb;
    import soc_map_pkg::*;
    import irq_pkg::*;

    // Roughly twice the expected run length
    localparam int          MaxCycles = 12000;
    localparam int unsigned Seed      = 32'h679fa70f;

    logic     clk = 1'b0;
    logic     ndmreset_n = 1'b0;
    logic     psel = 1'b0;
    logic     penable = 1'b0;
    logic     pwrite = 1'b0;
    paddr_t   paddr = '0;
    pdata_t   pwdata = '0;
    src_vec_t irq_sources = '0;
    pdata_t   prdata;
    logic     pready;
    logic     pslverr;
    logic     timer_irq;
    logic     ipi;
    logic     eip;
    logic     claim_rd;
    logic     claim_wr;
    int       errors = 0;
    int       checks = 0;
    int       cycles = 0;

    // Reference model state
    logic     m_rtc;
    logic     m_tirq;
    mtime_t   m_mtime;
    mtime_t   m_cmp = '1;
    src_vec_t m_pend;
    src_vec_t m_isvc;
    src_vec_t m_en = '0;
    prio_t    m_thr = '0;
    prio_t    m_prio [NumSources] = '{default: '0};

    always #5 clk = ~clk;

    irq_periph_top u_dut (
        .clk_i         (clk),
        .ndmreset_n    (ndmreset_n),
        .psel_i        (psel),
        .penable_i     (penable),
        .pwrite_i      (pwrite),
        .paddr_i       (paddr),
        .pwdata_i      (pwdata),
        .prdata_o      (prdata),
        .pready_o      (pready),
        .pslverr_o     (pslverr),
        .irq_sources_i (irq_sources),
        .timer_irq_o   (timer_irq),
        .ipi_o         (ipi),
        .eip_o         (eip)
    );

    function automatic paddr_t region_addr(input paddr_t base, input reg_off_t off);
        return base | paddr_t'(off);
    endfunction

    // Highest priority above threshold first, then lowest identifier
    function automatic irq_id_t expected_winner();
        irq_id_t id;
        id = '0;
        for (int p = int'(MaxPriority); p > int'(m_thr); p--) begin
            for (int i = 1; i < NumSources; i++) begin
                if (id == '0 && m_pend[i] && m_en[i] && int'(m_prio[i]) == p) begin
                    id = irq_id_t'(i);
                end
            end
        end
        return id;
    endfunction

    task automatic check_value(input string name, input pdata_t got, input pdata_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Both transfer tasks start and end on a falling edge
    task automatic apb_write(input paddr_t addr, input pdata_t data);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input paddr_t addr, output pdata_t data, output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;
        err = pslverr;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_expect(input string name, input paddr_t addr, input pdata_t exp);
        pdata_t data;
        logic   err;
        apb_read(addr, data, err);
        check_value(name, data, exp);
    endtask

    // ------------------------------------------------------------------
    // Reference model, timer and gateway
    // ------------------------------------------------------------------
    assign claim_rd = psel && penable && !pwrite && paddr == region_addr(PlicBase, ClaimOff);
    assign claim_wr = psel && penable && pwrite && paddr == region_addr(PlicBase, ClaimOff);

    always @(posedge clk or negedge ndmreset_n) begin
        src_vec_t pend_n;
        src_vec_t isvc_n;
        irq_id_t  win;
        if (!ndmreset_n) begin
            m_rtc <= 1'b0;
            m_mtime <= '0;
            m_tirq <= 1'b0;
            m_pend <= '0;
            m_isvc <= '0;
        end else begin
            m_rtc <= ~m_rtc;
            if (m_rtc) begin
                m_mtime <= m_mtime + mtime_t'(1);
            end
            m_tirq <= (m_mtime >= m_cmp);
            win = expected_winner();
            pend_n = m_pend | (irq_sources & ~m_isvc);
            pend_n[0] = 1'b0;
            isvc_n = m_isvc;
            if (claim_rd && win != '0) begin
                pend_n[win] = 1'b0;
                isvc_n[win] = 1'b1;
            end
            if (claim_wr && pwdata < NumSources) begin
                isvc_n[pwdata[$bits(irq_id_t)-1:0]] = 1'b0;
            end
            m_pend <= pend_n;
            m_isvc <= isvc_n;
        end
    end

    always @(negedge clk) begin
        if (ndmreset_n) begin
            check_value("timer_irq_o", pdata_t'(timer_irq), pdata_t'(m_tirq));
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MaxCycles) begin
            $display("ERROR: run stopped after %0d cycles, the tests did not finish", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        int unsigned k;
        pdata_t      data;
        pdata_t      first;
        pdata_t      target;
        logic        err;
        irq_id_t     win;
        src_vec_t    en;
        prio_t       p;
        void'($urandom(Seed));
        repeat (5) @(posedge clk);
        @(negedge clk);
        ndmreset_n = 1'b1;

        read_expect("mtimecmp_lo", region_addr(ClintBase, MtimecmpLoOff), '1);
        read_expect("mtimecmp_hi", region_addr(ClintBase, MtimecmpHiOff), '1);
        read_expect("msip", region_addr(ClintBase, MsipOff), '0);
        read_expect("enable", region_addr(PlicBase, EnableOff), '0);
        read_expect("threshold", region_addr(PlicBase, ThresholdOff), '0);
        read_expect("claim", region_addr(PlicBase, ClaimOff), '0);
        check_value("ipi_o", pdata_t'(ipi), '0);
        check_value("eip_o", pdata_t'(eip), '0);

        for (int v = 1; v >= 0; v--) begin
            apb_write(region_addr(ClintBase, MsipOff), pdata_t'(v));
            check_value("ipi_o", pdata_t'(ipi), pdata_t'(v));
            read_expect("msip", region_addr(ClintBase, MsipOff), pdata_t'(v));
        end

        // mtime advances once per two clocks
        k = $urandom_range(40, 4);
        apb_read(region_addr(ClintBase, MtimeLoOff), first, err);
        repeat (2 * k - 2) @(negedge clk);
        apb_read(region_addr(ClintBase, MtimeLoOff), data, err);
        check_value("mtime delta", data - first, pdata_t'(k));
        apb_write(region_addr(ClintBase, MtimecmpHiOff), '0);
        m_cmp[63:32] = '0;
        target = m_mtime[31:0] + pdata_t'($urandom_range(20, 1));
        apb_write(region_addr(ClintBase, MtimecmpLoOff), target);
        m_cmp[31:0] = target;
        while (!m_tirq) @(negedge clk);
        repeat (4) @(negedge clk);
        check_value("timer_irq_o", pdata_t'(timer_irq), 32'h1);
        apb_write(region_addr(ClintBase, MtimecmpLoOff), '1);
        m_cmp[31:0] = '1;
        apb_write(region_addr(ClintBase, MtimecmpHiOff), '1);
        m_cmp[63:32] = '1;
        @(negedge clk);
        check_value("timer_irq_o", pdata_t'(timer_irq), '0);

        for (int i = 0; i < 16; i++) begin
            apb_read(paddr_t'($urandom_range(32'hFFFF, 32'h2000)), data, err);
            check_value("pslverr_o", pdata_t'(err), 32'h1);
            check_value("prdata_o", data, '0);
            apb_read(paddr_t'($urandom_range(32'h1FFF, 0)) & 16'hFFFC, data, err);
            check_value("pslverr_o", pdata_t'(err), '0);
        end

        // Interrupt controller rounds
        for (int r = 0; r < 200; r++) begin
            irq_sources = src_vec_t'($urandom);
            for (int i = 1; i < NumSources; i++) begin
                p = prio_t'($urandom_range(MaxPriority, 0));
                apb_write(region_addr(PlicBase, PrioOff + reg_off_t'(4 * i)), pdata_t'(p));
                m_prio[i] = p;
            end
            en = src_vec_t'($urandom);
            apb_write(region_addr(PlicBase, EnableOff), pdata_t'(en));
            m_en = en;
            p = prio_t'($urandom_range(MaxPriority, 0));
            apb_write(region_addr(PlicBase, ThresholdOff), pdata_t'(p));
            m_thr = p;
            win = expected_winner();
            check_value("eip_o", pdata_t'(eip), pdata_t'(win != '0));
            read_expect("claim", region_addr(PlicBase, ClaimOff), pdata_t'(win));
            if (win != '0) begin
                irq_sources[win] = 1'b1;
                apb_read(region_addr(PlicBase, PendingOff), data, err);
                check_value("pending claimed bit", pdata_t'(data[win]), '0);
                apb_write(region_addr(PlicBase, ClaimOff), pdata_t'(win));
                apb_read(region_addr(PlicBase, PendingOff), data, err);
                check_value("pending completed bit", pdata_t'(data[win]), 32'h1);
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hw/soc_map_pkg.sv
hw/irq_pkg.sv
hw/apb_periph_decoder.sv
hw/clint_timer.sv
hw/plic_core.sv
hw/irq_periph_top.sv
sim/irq_periph_checker.sv
sim/irq_periph_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= irq_periph_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
